// File: bench/tb_clock.sv
/*
  testbench clock and reset source, 20 ns period
  reset stays high for the first 5 cycles
*/

`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic reset
);

  localparam int half_period = 10;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// File: bench/tb_div.sv
/*
  directed tests for the iterative divider with a reference model
  inputs change on the falling edge, responses are checked on the rising edge
*/

`timescale 1ns/1ns

module tb_div import div_pkg::*; ();

  localparam int bp_reqs     = 12;
  localparam int stream_reqs = 40;
  // requests per test: basic, latency, edge operands, random stream, back pressure
  localparam int total_reqs  = 10 + 1 + 12 + stream_reqs + bp_reqs;
  // about 40 cycles per request through the core, plus stalls
  localparam int cycle_limit = total_reqs * 40 + 500;
  // a busy core alone keeps req_rdy low for at most 33 cycles in a row
  localparam int stall_run   = 40;

  logic    clk;
  logic    reset;
  div_fn_e req_fn;
  word_t   req_a;
  word_t   req_b;
  logic    req_val;
  logic    req_rdy;
  result_t resp_result;
  logic    resp_val;
  logic    resp_rdy;

  result_t     exp_q[$];
  int          test_errors = 0;
  int          resp_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  logic [31:0] lfsr_state = 32'h61ecb6b4;
  logic        held_val = 1'b0;
  result_t     held_result;

  tb_clock clock0 (.clk(clk), .reset(reset));

  int_div_iterative dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // --------------------
  // reference model
  // --------------------

  function automatic result_t expected_result(input div_fn_e fn, input word_t a, input word_t b);
    logic  sgn;
    word_t ma;
    word_t mb;
    word_t q;
    word_t r;
    sgn = (fn == fn_signed);
    ma  = (sgn && a[31]) ? (32'd0 - a) : a;
    mb  = (sgn && b[31]) ? (32'd0 - b) : b;
    // restoring division by zero leaves all ones and the dividend
    if (mb == 32'd0) begin
      q = 32'hffffffff;
      r = ma;
    end else begin
      q = ma / mb;
      r = ma % mb;
    end
    if (sgn && (a[31] != b[31])) q = 32'd0 - q;
    if (sgn && a[31]) r = 32'd0 - r;
    return {r, q};
  endfunction

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'h80200003;
    return b;
  endfunction

  // one lfsr step per bit taken
  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  // --------------------
  // monitor and watchdog
  // --------------------

  always @(posedge clk) begin
    if (!reset) begin
      // a stalled response must not move
      if (held_val && resp_result !== held_result) begin
        $display("mismatch at %0t: resp_result changed while stalled, expected %h got %h",
                 $time, held_result, resp_result);
        resp_errors++;
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          $display("error at %0t: response arrived with no request outstanding", $time);
          resp_errors++;
        end else if (resp_result !== exp_q[0]) begin
          $display("mismatch at %0t: resp_result expected %h got %h",
                   $time, exp_q[0], resp_result);
          resp_errors++;
          void'(exp_q.pop_front());
        end else begin
          void'(exp_q.pop_front());
        end
      end
      held_val    = resp_val && !resp_rdy;
      held_result = resp_result;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles, %0d responses missing",
               cycles, exp_q.size());
      $display("Finished with errors");
      $finish;
    end
  end

  // --------------------
  // helpers
  // --------------------

  // offer one request and hold it until accepted, returns on a falling edge
  task automatic send_req(input div_fn_e fn, input word_t a, input word_t b);
    logic accepted;
    accepted = 1'b0;
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    req_val  = 1'b1;
    while (!accepted) begin
      @(posedge clk);
      accepted = req_rdy;
    end
    exp_q.push_back(expected_result(fn, a, b));
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = test_errors + resp_errors - errs_before;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("%-16s %s, %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
  endtask

  // --------------------
  // tests
  // --------------------

  task automatic basic_cases();
    int errs_before;
    errs_before = test_errors + resp_errors;
    if (req_rdy !== 1'b1) begin
      $display("mismatch at %0t: req_rdy expected 1 got %b", $time, req_rdy);
      test_errors++;
    end
    if (resp_val !== 1'b0) begin
      $display("mismatch at %0t: resp_val expected 0 got %b", $time, resp_val);
      test_errors++;
    end
    resp_rdy = 1'b1;
    send_req(fn_unsigned, 32'd100, 32'd7);
    send_req(fn_unsigned, 32'hffffffff, 32'd3);
    send_req(fn_unsigned, 32'd12345678, 32'd1000);
    send_req(fn_unsigned, 32'hdeadbeef, 32'h00012345);
    // every sign combination
    send_req(fn_signed, 32'd100, 32'd7);
    send_req(fn_signed, -32'd100, 32'd7);
    send_req(fn_signed, 32'd100, -32'd7);
    send_req(fn_signed, -32'd100, -32'd7);
    send_req(fn_signed, -32'd7, 32'd2);
    send_req(fn_signed, 32'd7, -32'd7);
    wait_drain();
    report_test("basic", errs_before);
  endtask

  task automatic latency_check();
    int errs_before;
    int k;
    errs_before = test_errors + resp_errors;
    resp_rdy = 1'b1;
    send_req(fn_unsigned, 32'd1000, 32'd9);
    // send_req returns on the falling edge right after acceptance
    k = 0;
    while (!resp_val && k < 100) begin
      @(negedge clk);
      k++;
    end
    if (k != 34) begin
      $display("mismatch at %0t: resp_val latency expected 34 got %0d", $time, k);
      test_errors++;
    end
    wait_drain();
    report_test("latency", errs_before);
  endtask

  task automatic edge_operands();
    int errs_before;
    errs_before = test_errors + resp_errors;
    resp_rdy = 1'b1;
    send_req(fn_unsigned, 32'd123, 32'd0);
    send_req(fn_signed, -32'd123, 32'd0);
    send_req(fn_unsigned, 32'd0, 32'd5);
    send_req(fn_signed, 32'd0, -32'd5);
    send_req(fn_signed, 32'h80000000, 32'hffffffff);
    send_req(fn_unsigned, 32'h80000000, 32'hffffffff);
    send_req(fn_signed, 32'h80000000, 32'd1);
    send_req(fn_unsigned, 32'd5, 32'd100);
    send_req(fn_signed, -32'd5, 32'd100);
    send_req(fn_unsigned, 32'd5, 32'hffffffff);
    send_req(fn_unsigned, 32'hdeadbeef, 32'd1);
    send_req(fn_signed, 32'hdeadbeef, 32'd1);
    wait_drain();
    report_test("edge operands", errs_before);
  endtask

  task automatic random_stream();
    int      errs_before;
    word_t   r;
    div_fn_e fn;
    word_t   a;
    word_t   b;
    errs_before = test_errors + resp_errors;
    resp_rdy = 1'b1;
    for (int i = 0; i < stream_reqs; i++) begin
      r  = rand_bits(1);
      fn = r[0] ? fn_signed : fn_unsigned;
      a  = rand_bits(32);
      // spread the divisor size so quotients vary
      b  = rand_bits(32);
      b  = b >> rand_bits(5);
      send_req(fn, a, b);
    end
    wait_drain();
    report_test("random stream", errs_before);
  endtask

  task automatic back_pressure();
    int      errs_before;
    int      stall;
    int      n_sent;
    int      cyc;
    int      low_run;
    logic    saw_low;
    logic    accepted;
    word_t   r;
    div_fn_e fn;
    word_t   a;
    word_t   b;
    errs_before = test_errors + resp_errors;
    // long enough for all three stages to fill and stall
    stall    = 80 + int'(rand_bits(5));
    n_sent   = 0;
    cyc      = 0;
    low_run  = 0;
    saw_low  = 1'b0;
    accepted = 1'b1;
    resp_rdy = 1'b0;
    while (n_sent < bp_reqs) begin
      // new operands only once the previous offer was taken
      if (accepted) begin
        r       = rand_bits(1);
        fn      = r[0] ? fn_signed : fn_unsigned;
        a       = rand_bits(32);
        b       = rand_bits(16);
        req_fn  = fn;
        req_a   = a;
        req_b   = b;
        req_val = 1'b1;
      end
      @(posedge clk);
      accepted = req_rdy;
      if (req_rdy) begin
        low_run = 0;
      end else begin
        low_run++;
      end
      // only a stall from the response side holds req_rdy low this long
      if (low_run > stall_run) saw_low = 1'b1;
      if (accepted) begin
        exp_q.push_back(expected_result(fn, a, b));
        n_sent++;
      end
      @(negedge clk);
      cyc++;
      if (accepted) req_val = 1'b0;
      // held low first, then a random ready pattern
      if (cyc < stall) begin
        resp_rdy = 1'b0;
      end else begin
        r = rand_bits(1);
        resp_rdy = r[0];
      end
    end
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    wait_drain();
    // no extra response may follow the last one
    repeat (4) @(negedge clk);
    if (!saw_low) begin
      $display("error at %0t: req_rdy never stayed low from a stall while resp_rdy was low",
               $time);
      test_errors++;
    end
    report_test("back pressure", errs_before);
  endtask

  // --------------------
  // sequence
  // --------------------

  initial begin
    req_fn   = fn_unsigned;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    @(negedge reset);
    @(negedge clk);
    basic_cases();
    latency_check();
    edge_operands();
    random_stream();
    back_pressure();
    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, test_errors + resp_errors);
    if (test_errors + resp_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: common/div_pkg.sv
/*
  shared types and constants for the iterative integer divider
  imported by every stage and by the testbench
*/

package div_pkg;

  // --------------------
  // widths
  // --------------------

  // operand, quotient or remainder
  typedef logic [31:0] word_t;

  // response word: remainder in the upper half, quotient in the lower half
  typedef logic [63:0] result_t;

  // iteration counter, counts 31 down to 0
  typedef logic [4:0] count_t;

  // one iteration per quotient bit
  localparam int div_iters = 32;

  // --------------------
  // encodings
  // --------------------

  // request function bit
  typedef enum logic {
    fn_unsigned = 1'b0,
    fn_signed   = 1'b1
  } div_fn_e;

  // core controller states
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } iter_state_e;

endpackage

// File: divider/div_iter.sv
/*
  second divider stage: restoring shift-and-subtract over 32 cycles
  takes magnitudes from the unpack stage, hands unsigned results onward
*/

`timescale 1ns/1ns

module div_iter import div_pkg::*; (
  input  logic  clk,
  input  logic  reset,

  // from the unpack stage
  input  logic  u_val,
  output logic  u_rdy,
  input  word_t u_mag_a,
  input  word_t u_mag_b,
  input  logic  u_quot_neg,
  input  logic  u_rem_neg,

  // toward the sign fix-up stage
  output logic  i_val,
  input  logic  i_rdy,
  output word_t i_quot,
  output word_t i_rem,
  output logic  i_quot_neg,
  output logic  i_rem_neg
);

  // remainder/quotient register is one bit wider than two words
  // the spare top bit carries the borrow of the trial subtraction
  localparam int rq_w = 2 * div_iters + 1;

  // counter value loaded on entry to calc
  localparam count_t last_iter = count_t'(div_iters - 1);

  iter_state_e     state;
  count_t          count;

  logic [rq_w-1:0] rq_reg;
  logic [rq_w-1:0] div_reg;
  logic [rq_w-1:0] rq_shift;
  logic [rq_w-1:0] rq_diff;
  logic [rq_w-1:0] rq_next;

  logic            load;
  logic            take;
  logic            quot_neg_reg;
  logic            rem_neg_reg;

  // --------------------
  // handshake
  // --------------------

  // only an idle core accepts, a done core waits for the next stage
  assign u_rdy = (state == idle);
  assign i_val = (state == done);

  assign load = u_val && u_rdy;
  assign take = i_val && i_rdy;

  // --------------------
  // controller
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      count <= '0;
    end else begin
      case (state)
        idle: begin
          if (load) begin
            state <= calc;
            count <= last_iter;
          end
        end

        calc: begin
          // count hits zero on the last of the 32 iterations
          if (count == '0) begin
            state <= done;
          end else begin
            count <= count - 1'b1;
          end
        end

        done: begin
          if (take) begin
            state <= idle;
          end
        end

        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // --------------------
  // one iteration
  // --------------------

  always_comb begin
    rq_shift = rq_reg << 1;
    // divisor sits over the remainder half, so the low half passes through
    rq_diff  = rq_shift - div_reg;
    if (rq_diff[rq_w-1]) begin
      // borrow: restore the shifted value, quotient bit 0
      rq_next = {rq_shift[rq_w-1:1], 1'b0};
    end else begin
      // fits: keep the difference, quotient bit 1
      rq_next = {rq_diff[rq_w-1:1], 1'b1};
    end
  end

  // datapath registers, written on load or while iterating
  always_ff @(posedge clk) begin
    if (load) begin
      rq_reg       <= {{(div_iters + 1){1'b0}}, u_mag_a};
      div_reg      <= {1'b0, u_mag_b, {div_iters{1'b0}}};
      quot_neg_reg <= u_quot_neg;
      rem_neg_reg  <= u_rem_neg;
    end else if (state == calc) begin
      rq_reg <= rq_next;
    end
  end

  // --------------------
  // results
  // --------------------

  // quotient bits were shifted in at the bottom, remainder ends above them
  assign i_quot     = rq_reg[div_iters-1:0];
  assign i_rem      = rq_reg[2*div_iters-1:div_iters];
  assign i_quot_neg = quot_neg_reg;
  assign i_rem_neg  = rem_neg_reg;

endmodule

// File: divider/div_sign_fix.sv
/*
  third divider stage: applies the recorded signs to quotient and remainder
  and holds the packed response until the consumer takes it
*/

`timescale 1ns/1ns

module div_sign_fix import div_pkg::*; (
  input  logic    clk,
  input  logic    reset,

  // from the core
  input  logic    i_val,
  output logic    i_rdy,
  input  word_t   i_quot,
  input  word_t   i_rem,
  input  logic    i_quot_neg,
  input  logic    i_rem_neg,

  // response side
  output logic    resp_val,
  input  logic    resp_rdy,
  output result_t resp_result
);

  logic  full;
  logic  in_go;
  word_t quot_fixed;
  word_t rem_fixed;

  // --------------------
  // sign fix-up
  // --------------------

  always_comb begin
    quot_fixed = i_quot;
    rem_fixed  = i_rem;
    // negation wraps modulo 2^32
    if (i_quot_neg) begin
      quot_fixed = ~i_quot + 1'b1;
    end
    if (i_rem_neg) begin
      rem_fixed = ~i_rem + 1'b1;
    end
  end

  // --------------------
  // slot handshake
  // --------------------

  assign i_rdy    = !full || resp_rdy;
  assign in_go    = i_val && i_rdy;
  assign resp_val = full;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_go) begin
      full <= 1'b1;
    end else if (resp_rdy) begin
      full <= 1'b0;
    end
  end

  // remainder above quotient
  always_ff @(posedge clk) begin
    if (in_go) begin
      resp_result <= {rem_fixed, quot_fixed};
    end
  end

endmodule

// File: divider/div_unpack.sv
/*
  first divider stage: captures a request, turns signed operands into
  magnitudes and records which results must be negated later
*/

`timescale 1ns/1ns

module div_unpack import div_pkg::*; (
  input  logic    clk,
  input  logic    reset,

  // request side
  input  div_fn_e req_fn,
  input  word_t   req_a,
  input  word_t   req_b,
  input  logic    req_val,
  output logic    req_rdy,

  // toward the core
  output logic    u_val,
  input  logic    u_rdy,
  output word_t   u_mag_a,
  output word_t   u_mag_b,
  output logic    u_quot_neg,
  output logic    u_rem_neg
);

  logic  full;
  logic  is_signed;
  logic  req_go;
  word_t mag_a;
  word_t mag_b;

  // --------------------
  // operand conditioning
  // --------------------

  assign is_signed = (req_fn == fn_signed);

  // two's complement absolute value, most negative stays 2^31 unsigned
  assign mag_a = (is_signed && req_a[31]) ? (~req_a + 1'b1) : req_a;
  assign mag_b = (is_signed && req_b[31]) ? (~req_b + 1'b1) : req_b;

  // --------------------
  // slot handshake
  // --------------------

  // a full slot can still take a new request if its content leaves this edge
  assign req_rdy = !full || u_rdy;
  assign req_go  = req_val && req_rdy;
  assign u_val   = full;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (req_go) begin
      full <= 1'b1;
    end else if (u_rdy) begin
      // downstream took the slot (or it was already empty)
      full <= 1'b0;
    end
  end

  // payload, only written on a transfer in
  always_ff @(posedge clk) begin
    if (req_go) begin
      u_mag_a    <= mag_a;
      u_mag_b    <= mag_b;
      // quotient sign follows the xor of the operand signs
      u_quot_neg <= is_signed && (req_a[31] ^ req_b[31]);
      // remainder takes the sign of the dividend
      u_rem_neg  <= is_signed && req_a[31];
    end
  end

endmodule

// File: divider/int_div_iterative.sv
/*
  iterative 32-bit integer divider, three val/rdy stages in a row
  response holds the remainder in the upper word and the quotient below
*/

`timescale 1ns/1ns

module int_div_iterative import div_pkg::*; (
  input  logic    clk,
  input  logic    reset,

  // request side
  input  div_fn_e req_fn,
  input  word_t   req_a,
  input  word_t   req_b,
  input  logic    req_val,
  output logic    req_rdy,

  // response side
  output result_t resp_result,
  output logic    resp_val,
  input  logic    resp_rdy
);

  // --------------------
  // stage 1 to stage 2
  // --------------------
  logic  u_val;
  logic  u_rdy;
  word_t u_mag_a;
  word_t u_mag_b;
  logic  u_quot_neg;
  logic  u_rem_neg;

  // --------------------
  // stage 2 to stage 3
  // --------------------
  logic  i_val;
  logic  i_rdy;
  word_t i_quot;
  word_t i_rem;
  logic  i_quot_neg;
  logic  i_rem_neg;

  // operand unpacking
  div_unpack unpack0 (
    .clk        (clk),
    .reset      (reset),
    .req_fn     (req_fn),
    .req_a      (req_a),
    .req_b      (req_b),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .u_val      (u_val),
    .u_rdy      (u_rdy),
    .u_mag_a    (u_mag_a),
    .u_mag_b    (u_mag_b),
    .u_quot_neg (u_quot_neg),
    .u_rem_neg  (u_rem_neg)
  );

  // 32-cycle restoring core
  div_iter iter0 (
    .clk        (clk),
    .reset      (reset),
    .u_val      (u_val),
    .u_rdy      (u_rdy),
    .u_mag_a    (u_mag_a),
    .u_mag_b    (u_mag_b),
    .u_quot_neg (u_quot_neg),
    .u_rem_neg  (u_rem_neg),
    .i_val      (i_val),
    .i_rdy      (i_rdy),
    .i_quot     (i_quot),
    .i_rem      (i_rem),
    .i_quot_neg (i_quot_neg),
    .i_rem_neg  (i_rem_neg)
  );

  // sign fix-up and response slot
  div_sign_fix sign_fix0 (
    .clk         (clk),
    .reset       (reset),
    .i_val       (i_val),
    .i_rdy       (i_rdy),
    .i_quot      (i_quot),
    .i_rem       (i_rem),
    .i_quot_neg  (i_quot_neg),
    .i_rem_neg   (i_rem_neg),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the divider testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -sv \
  --top-module tb_div \
  -f verilog.f \
  -Mdir obj_dir \
  -o sim_div

./obj_dir/sim_div | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: verilog.f
common/div_pkg.sv
divider/div_unpack.sv
divider/div_iter.sv
divider/div_sign_fix.sv
divider/int_div_iterative.sv
bench/tb_clock.sv
bench/tb_div.sv
